// ==== sources.f ====
+incdir+source
source/cart_pkg.sv
source/dl_if.sv
source/cart_regs.sv
source/header_probe.sv
source/cheat_loader.sv
source/ram_clear.sv
source/backup_sequencer.sv
source/cart_loader_top.sv
tests/tb_clock.sv
tests/cart_loader_tb.sv

// ==== Bender.yml ====
package:
  name: cart_loader

sources:
  - include_dirs:
      - source
    files:
      - source/cart_pkg.sv
      - source/dl_if.sv
      - source/cart_regs.sv
      - source/header_probe.sv
      - source/cheat_loader.sv
      - source/ram_clear.sv
      - source/backup_sequencer.sv
      - source/cart_loader_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_clock.sv
      - tests/cart_loader_tb.sv

// ==== tests/cart_loader_tb.sv ====
// Cartridge loader testbench
// Header case table, AXI4-Lite driver, storage model and monitors
// for RAM clear, cheat records and backup sectors

`include "cart_consts.svh"

module cart_loader_tb;
	localparam int N_CASES       = 6;
	localparam int FILL_LEN      = 1 << `CLEAR_ADDR_W;
	localparam int SECTOR_CYCLES = 12;

	typedef struct packed {
		logic [2:0]  mode;
		logic [15:0] w0;
		logic [15:0] w2;
		logic [15:0] size_w;
		logic [15:0] ram_w;
		logic [1:0]  region;
		logic [1:0]  pat;
		logic [7:0]  exp_type;
		logic [23:0] exp_rom;
		logic [23:0] exp_ram;
		logic        exp_pal;
	} case_t;

	logic                     clk_sys;
	logic                     RESET;
	logic [`AXI_ADDR_W-1:0]   s_axi_awaddr;
	logic                     s_axi_awvalid;
	logic                     s_axi_awready;
	logic [31:0]              s_axi_wdata;
	logic                     s_axi_wvalid;
	logic                     s_axi_wready;
	logic [1:0]               s_axi_bresp;
	logic                     s_axi_bvalid;
	logic                     s_axi_bready;
	logic [`AXI_ADDR_W-1:0]   s_axi_araddr;
	logic                     s_axi_arvalid;
	logic                     s_axi_arready;
	logic [31:0]              s_axi_rdata;
	logic [1:0]               s_axi_rresp;
	logic                     s_axi_rvalid;
	logic                     s_axi_rready;
	logic                     dl_download;
	logic [`DL_INDEX_W-1:0]   dl_index;
	logic [`DL_ADDR_W-1:0]    dl_addr;
	logic [`DL_DATA_W-1:0]    dl_data;
	logic                     dl_wr;
	logic                     img_mounted;
	logic                     img_readonly;
	logic [63:0]              img_size;
	logic                     sd_ack;
	logic [`CLEAR_ADDR_W-1:0] fill_addr;
	logic [7:0]               fill_data;
	logic                     fill_we;
	logic [127:0]             cheat_code;
	logic                     cheat_strobe;
	logic [31:0]              sd_lba;
	logic                     sd_rd;
	logic                     sd_wr;

	case_t  cases [N_CASES];
	integer seed = 32'h4895;
	int     mismatches = 0;
	int     other_errors = 0;
	int     fill_count = 0;
	int     rd_count = 0;
	int     wr_count = 0;
	int     strobes = 0;
	int     cycles = 0;
	int     limit = 0;
	logic [1:0] cur_pat = 2'd0;

	tb_clock clock_i (.clk_sys, .RESET);

	cart_loader_top dut_i (.*);

	// ====================
	// Helpers
	// ====================
	task automatic check_equal(input string what, input logic [127:0] got,
			input logic [127:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Power-on byte for each pattern
	function automatic logic [7:0] fill_byte(input logic [1:0] pat, input int a);
		case (pat)
			2'd0:    return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1:    return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic add_case(input int i, input logic [2:0] mode, input logic [15:0] w0,
			input logic [15:0] w2, input logic [15:0] size_w, input logic [15:0] ram_w,
			input logic [1:0] region, input logic [1:0] pat, input logic [7:0] exp_type,
			input logic [23:0] exp_rom, input logic [23:0] exp_ram, input logic exp_pal);
		cases[i] = {mode, w0, w2, size_w, ram_w, region, pat, exp_type, exp_rom, exp_ram,
			exp_pal};
	endtask

	task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge clk_sys);
		s_axi_awaddr  = addr;
		s_axi_wdata   = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid  = 1'b1;
		s_axi_bready  = 1'b1;
		do @(negedge clk_sys); while (!s_axi_awready);
		check_equal("wready with awready", s_axi_wready, 1'b1);
		// Valid stays up through the accepting edge
		@(negedge clk_sys);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		while (!s_axi_bvalid) @(negedge clk_sys);
		check_equal("write response", s_axi_bresp, 2'b00);
		@(negedge clk_sys);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		@(negedge clk_sys);
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		s_axi_rready  = 1'b1;
		do @(negedge clk_sys); while (!s_axi_arready);
		@(negedge clk_sys);
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid) @(negedge clk_sys);
		check_equal("read response", s_axi_rresp, 2'b00);
		data = s_axi_rdata;
		@(negedge clk_sys);
		s_axi_rready = 1'b0;
	endtask

	task automatic wait_backup_idle();
		logic [31:0] status;
		repeat (3) @(negedge clk_sys);
		do axi_read(`REG_STATUS, status); while (status[10]);
	endtask

	task automatic send_word(input logic [`DL_ADDR_W-1:0] a, input logic [15:0] d);
		@(negedge clk_sys);
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
	endtask

	task automatic cart_download(input case_t c);
		logic [`DL_ADDR_W-1:0] size_a;
		logic [`DL_ADDR_W-1:0] ram_a;
		case (c.mode)
			cart_pkg::HIROM: begin
				size_a = `HDR_HI_SIZE;
				ram_a  = `HDR_HI_RAM;
			end
			cart_pkg::EXHIROM: begin
				size_a = `HDR_EX_SIZE;
				ram_a  = `HDR_EX_RAM;
			end
			default: begin
				size_a = `HDR_LO_SIZE;
				ram_a  = `HDR_LO_RAM;
			end
		endcase
		@(negedge clk_sys);
		dl_index    = `IDX_CART;
		dl_download = 1'b1;
		send_word('0, c.w0);
		send_word(`DL_ADDR_W'd2, c.w2);
		send_word(size_a, c.size_w);
		send_word(ram_a, c.ram_w);
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		dl_download = 1'b0;
	endtask

	// ====================
	// Monitors and storage model
	// ====================
	always @(negedge clk_sys) begin
		if (fill_we) begin
			check_equal("fill_addr", fill_addr, fill_count);
			check_equal("fill_data", fill_data, fill_byte(cur_pat, fill_count));
			fill_count++;
		end
		if (cheat_strobe)
			strobes++;
	end

	initial begin : storage_model
		integer ack_len;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!RESET && (sd_rd || sd_wr)) begin
				assert (!(sd_rd && sd_wr)) else begin
					other_errors++;
					$display("Storage request with read and write both set at %0t", $time);
				end
				check_equal("sd_lba", sd_lba, rd_count + wr_count);
				if (sd_rd)
					rd_count++;
				else
					wr_count++;
				// Sector transfer of random length
				ack_len = 1 + ({$random(seed)} % 8);
				sd_ack  = 1'b1;
				repeat (ack_len) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, a handshake or sequence never finished", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ====================
	// Main sequence
	// ====================
	initial begin
		logic [31:0]  rdata;
		logic [15:0]  words [8];
		logic [127:0] exp_code;
		int           sectors;
		int           total_sectors;

		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		dl_download   = 1'b0;
		dl_index      = '0;
		dl_addr       = '0;
		dl_data       = '0;
		dl_wr         = 1'b0;
		img_mounted   = 1'b1;
		img_readonly  = 1'b0;
		img_size      = 64'h2000;

		add_case(0, cart_pkg::AUTO, 16'h2A1B, 16'h0100, 16'h0900, 16'h0005, 2'd0, 2'd0,
			8'h2A, 24'h1FFFFF, 24'h0007FF, 1'b1);
		add_case(1, cart_pkg::AUTO, 16'h0500, 16'h0000, 16'h0B00, 16'h0002, 2'd2, 2'd1,
			8'h05, 24'h3FFFFF, 24'h000000, 1'b1);
		add_case(2, cart_pkg::NO_HEADER, 16'h3321, 16'h0100, 16'h0A00, 16'h0003, 2'd1, 2'd2,
			8'h00, 24'h3FFFFF, 24'h000000, 1'b0);
		add_case(3, cart_pkg::LOROM, 16'h7712, 16'h0000, 16'h0A00, 16'h0003, 2'd0, 2'd3,
			8'h00, 24'h0FFFFF, 24'h001FFF, 1'b0);
		add_case(4, cart_pkg::HIROM, 16'h1234, 16'h0100, 16'h0C00, 16'h0002, 2'd3, 2'd0,
			8'h01, 24'h3FFFFF, 24'h000FFF, 1'b1);
		add_case(5, cart_pkg::EXHIROM, 16'h0000, 16'h0100, 16'h0D00, 16'h0001, 2'd0, 2'd1,
			8'h02, 24'h7FFFFF, 24'h0007FF, 1'b1);

		// Load and save per case, each sector bounded in cycles
		total_sectors = 0;
		for (int i = 0; i < N_CASES; i++)
			if (cases[i].exp_ram != 0)
				total_sectors += (cases[i].exp_ram >> `SECTOR_SHIFT) + 1;
		limit = N_CASES * (FILL_LEN + 200) + total_sectors * 2 * SECTOR_CYCLES + 2000;

		wait (!RESET);
		@(negedge clk_sys);

		// Register readback after reset
		axi_read(`REG_STATUS, rdata);
		check_equal("STATUS bk_busy after reset", rdata[10], 1'b0);
		axi_write(`REG_CTRL, 32'h0000_0233);
		axi_read(`REG_CTRL, rdata);
		check_equal("CTRL readback", rdata, 32'h0000_0233);
		axi_read(`REG_CMD, rdata);
		check_equal("unmapped register read", rdata, 32'd0);

		for (int i = 0; i < N_CASES; i++) begin
			cur_pat = cases[i].pat;
			axi_write(`REG_CTRL, {22'd0, cases[i].pat, 2'd0, cases[i].region, 1'b0,
				cases[i].mode});
			fill_count = 0;
			rd_count   = 0;
			wr_count   = 0;
			cart_download(cases[i]);

			while (fill_count < FILL_LEN) @(negedge clk_sys);
			repeat (3) @(negedge clk_sys);
			check_equal("fill_we after clear", fill_we, 1'b0);
			check_equal("fill write count", fill_count, FILL_LEN);

			// Automatic load after the download
			wait_backup_idle();
			sectors = (cases[i].exp_ram != 0) ? (cases[i].exp_ram >> `SECTOR_SHIFT) + 1 : 0;
			check_equal("auto load sector reads", rd_count, sectors);
			check_equal("auto load sector writes", wr_count, 0);

			axi_read(`REG_ROM_MASK, rdata);
			check_equal("ROM mask", rdata, {8'd0, cases[i].exp_rom});
			axi_read(`REG_RAM_MASK, rdata);
			check_equal("RAM mask", rdata, {8'd0, cases[i].exp_ram});
			axi_read(`REG_STATUS, rdata);
			check_equal("ROM type", rdata[7:0], cases[i].exp_type);
			check_equal("PAL flag", rdata[8], cases[i].exp_pal);
			check_equal("backup enable", rdata[9], cases[i].exp_ram != 0);

			// Save pass
			rd_count = 0;
			wr_count = 0;
			axi_write(`REG_CMD, 32'h2);
			wait_backup_idle();
			check_equal("save sector writes", wr_count, sectors);
			check_equal("save sector reads", rd_count, 0);

			if (sectors == 0) begin
				axi_write(`REG_CMD, 32'h1);
				repeat (20) @(negedge clk_sys);
				check_equal("load without backup RAM", rd_count + wr_count, 0);
			end
		end

		// One cheat record
		for (int k = 0; k < 8; k++)
			words[k] = $random(seed);
		exp_code = {words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]};
		strobes = 0;
		@(negedge clk_sys);
		dl_index    = `IDX_CHEAT;
		dl_download = 1'b1;
		for (int k = 0; k < 8; k++)
			send_word(2 * k, words[k]);
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		dl_download = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_equal("cheat strobe count", strobes, 1);
		check_equal("cheat record", cheat_code, exp_code);

		$display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end
endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock and reset
// 10-unit clock, reset held for four cycles

module tb_clock (
	output logic clk_sys,
	output logic RESET
);
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		RESET = 1'b1;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
	end
endmodule

// ==== source/cart_loader_top.sv ====
// Cartridge loader top level
// Download bus, register block, header probe, cheats, RAM clear, backup

`include "cart_consts.svh"

module cart_loader_top (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic [`AXI_ADDR_W-1:0]   s_axi_awaddr,
	input  logic                     s_axi_awvalid,
	output logic                     s_axi_awready,
	input  logic [31:0]              s_axi_wdata,
	input  logic                     s_axi_wvalid,
	output logic                     s_axi_wready,
	output logic [1:0]               s_axi_bresp,
	output logic                     s_axi_bvalid,
	input  logic                     s_axi_bready,
	input  logic [`AXI_ADDR_W-1:0]   s_axi_araddr,
	input  logic                     s_axi_arvalid,
	output logic                     s_axi_arready,
	output logic [31:0]              s_axi_rdata,
	output logic [1:0]               s_axi_rresp,
	output logic                     s_axi_rvalid,
	input  logic                     s_axi_rready,
	input  logic                     dl_download,
	input  logic [`DL_INDEX_W-1:0]   dl_index,
	input  logic [`DL_ADDR_W-1:0]    dl_addr,
	input  logic [`DL_DATA_W-1:0]    dl_data,
	input  logic                     dl_wr,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic [63:0]              img_size,
	input  logic                     sd_ack,
	output logic [`CLEAR_ADDR_W-1:0] fill_addr,
	output logic [7:0]               fill_data,
	output logic                     fill_we,
	output logic [127:0]             cheat_code,
	output logic                     cheat_strobe,
	output logic [31:0]              sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr
);
	cart_pkg::cart_info_t  info;
	cart_pkg::hdr_mode_e   hdr_mode;
	cart_pkg::fill_pat_e   fill_pat;
	cart_pkg::cheat_code_t cheat_rec;
	logic [1:0]            region_sel;
	logic                  load_req;
	logic                  save_req;
	logic                  bk_busy;
	logic                  dl_end;

	// ====================
	// Download bus
	// ====================
	dl_if dl_bus ();

	assign dl_bus.download = dl_download;
	assign dl_bus.index    = dl_index;
	assign dl_bus.addr     = dl_addr;
	assign dl_bus.data     = dl_data;
	assign dl_bus.wr       = dl_wr;

	// ====================
	// Blocks
	// ====================
	cart_regs regs_i (
		.clk_sys, .RESET,
		.s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
		.s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
		.s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
		.s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
		.s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
		.info, .bk_busy,
		.hdr_mode, .region_sel, .fill_pat, .load_req, .save_req
	);

	header_probe probe_i (
		.clk_sys, .RESET,
		.dl (dl_bus.sink),
		.hdr_mode, .region_sel, .img_mounted, .img_readonly,
		.dl_end, .info
	);

	cheat_loader cheat_i (
		.clk_sys, .RESET,
		.dl           (dl_bus.sink),
		.cheat_code   (cheat_rec),
		.cheat_strobe
	);

	assign cheat_code = cheat_rec;

	ram_clear clear_i (
		.clk_sys, .RESET,
		.dl (dl_bus.sink),
		.fill_pat, .fill_addr, .fill_data, .fill_we
	);

	backup_sequencer backup_i (
		.clk_sys, .RESET,
		.info, .dl_end, .img_size, .load_req, .save_req,
		.sd_ack, .sd_lba, .sd_rd, .sd_wr, .bk_busy
	);

endmodule

// ==== source/backup_sequencer.sv ====
// Backup RAM sector sequencer
// Loads and saves cartridge RAM one storage sector at a time

`include "cart_consts.svh"

module backup_sequencer (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  cart_pkg::cart_info_t info,
	input  logic                 dl_end,
	input  logic [63:0]          img_size,
	input  logic                 load_req,
	input  logic                 save_req,
	input  logic                 sd_ack,
	output logic [31:0]          sd_lba,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic                 bk_busy
);
	logic        old_ack;
	logic        loading;
	logic [31:0] last_lba;

	// Last sector index covering the whole RAM
	assign last_lba = {8'd0, info.ram_mask} >> `SECTOR_SHIFT;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ack <= 1'b0;
			loading <= 1'b0;
			bk_busy <= 1'b0;
			sd_lba  <= 32'd0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
		end else begin
			old_ack <= sd_ack;

			// Request drops once the storage side has taken it
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (info.bk_enable && (load_req || save_req)) begin
					bk_busy <= 1'b1;
					loading <= load_req;
					sd_lba  <= 32'd0;
					sd_rd   <= load_req;
					sd_wr   <= ~load_req;
				end
				// Pull saved RAM in right after a new cartridge
				if (info.bk_enable && dl_end && img_size != 64'd0) begin
					bk_busy <= 1'b1;
					loading <= 1'b1;
					sd_lba  <= 32'd0;
					sd_rd   <= 1'b1;
					sd_wr   <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					bk_busy <= 1'b0;
					loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= loading;
					sd_wr  <= ~loading;
				end
			end
		end
	end

endmodule

// ==== source/ram_clear.sv ====
// Work RAM clear sequencer
// Sweeps all addresses once per cart download with a fill pattern

`include "cart_consts.svh"

module ram_clear (
	input  logic                     clk_sys,
	input  logic                     RESET,
	dl_if.sink                       dl,
	input  cart_pkg::fill_pat_e      fill_pat,
	output logic [`CLEAR_ADDR_W-1:0] fill_addr,
	output logic [7:0]               fill_data,
	output logic                     fill_we
);
	logic cart_dl;
	logic old_dl;

	assign cart_dl = dl.download && (dl.index == `IDX_CART);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_dl    <= 1'b0;
			fill_we   <= 1'b0;
			fill_addr <= '0;
		end else begin
			old_dl <= cart_dl;

			if (cart_dl && !old_dl)
				fill_we <= 1'b1;
			// Stop after the top address is written
			if (&fill_addr)
				fill_we <= 1'b0;

			if (fill_we)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	// Patterns of the different console revisions
	always_comb begin
		case (fill_pat)
			cart_pkg::PAT_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::PAT_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::PAT_55:   fill_data = 8'h55;
			default:            fill_data = 8'hFF;
		endcase
	end

endmodule

// ==== source/cheat_loader.sv ====
// Cheat record assembly
// Eight 16-bit words make one 128-bit record

`include "cart_consts.svh"

module cheat_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	dl_if.sink                    dl,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                  cheat_strobe
);
	logic cheat_wr;

	assign cheat_wr = dl.download && (dl.index == `IDX_CHEAT) && dl.wr;

	// Low word first within each field
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (dl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dl.data;
				4'd2:  cheat_code.flags[31:16]   <= dl.data;
				4'd4:  cheat_code.address[15:0]  <= dl.data;
				4'd6:  cheat_code.address[31:16] <= dl.data;
				4'd8:  cheat_code.compare[15:0]  <= dl.data;
				4'd10: cheat_code.compare[31:16] <= dl.data;
				4'd12: cheat_code.replace[15:0]  <= dl.data;
				4'd14: cheat_code.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	// Last word completes the record
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= cheat_wr && (dl.addr[3:0] == 4'd14);
	end

endmodule

// ==== source/header_probe.sv ====
// Cartridge header probe
// ROM type, sizes, region, derived masks, PAL and backup enable

`include "cart_consts.svh"

module header_probe (
	input  logic                 clk_sys,
	input  logic                 RESET,
	dl_if.sink                   dl,
	input  cart_pkg::hdr_mode_e  hdr_mode,
	input  logic [1:0]           region_sel,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	output logic                 dl_end,
	output cart_pkg::cart_info_t info
);
	logic                  cart_dl;
	logic                  old_dl;
	logic                  hdr_fixed;
	logic [`DL_ADDR_W-1:0] size_addr;
	logic [`DL_ADDR_W-1:0] ram_addr;
	logic [3:0]            rom_size;
	logic [3:0]            ram_size;
	logic                  rom_region;
	logic [7:0]            rom_type;
	logic                  pal;
	logic                  bk_enable;
	logic [23:0]           rom_mask;
	logic [23:0]           ram_mask;

	assign cart_dl = dl.download && (dl.index == `IDX_CART);
	assign dl_end  = old_dl & ~cart_dl;

	// Where the size bytes sit for a forced mapping
	always_comb begin
		hdr_fixed = 1'b1;
		case (hdr_mode)
			cart_pkg::LOROM: begin
				size_addr = `HDR_LO_SIZE;
				ram_addr  = `HDR_LO_RAM;
			end
			cart_pkg::HIROM: begin
				size_addr = `HDR_HI_SIZE;
				ram_addr  = `HDR_HI_RAM;
			end
			cart_pkg::EXHIROM: begin
				size_addr = `HDR_EX_SIZE;
				ram_addr  = `HDR_EX_RAM;
			end
			default: begin
				hdr_fixed = 1'b0;
				size_addr = '0;
				ram_addr  = '0;
			end
		endcase
	end

	assign rom_mask = (24'd1024 << rom_size) - 24'd1;
	assign ram_mask = (ram_size != 4'd0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_dl     <= 1'b0;
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_region <= 1'b0;
			rom_type   <= 8'd0;
			pal        <= 1'b0;
			bk_enable  <= 1'b0;
		end else begin
			old_dl <= cart_dl;

			if (cart_dl && dl.wr) begin
				// First word carries the packed sizes and type
				if (dl.addr == '0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					if (hdr_mode == cart_pkg::AUTO && dl.data[7:0] != 8'd0)
						{ram_size, rom_size} <= dl.data[7:0];
					case (hdr_mode)
						cart_pkg::HIROM:   rom_type <= 8'd1;
						cart_pkg::EXHIROM: rom_type <= 8'd2;
						cart_pkg::AUTO:    rom_type <= dl.data[15:8];
						default:           rom_type <= 8'd0;
					endcase
				end
				if (dl.addr == `DL_ADDR_W'd2)
					rom_region <= dl.data[8];
				if (hdr_fixed && dl.addr == size_addr)
					rom_size <= dl.data[11:8];
				if (hdr_fixed && dl.addr == ram_addr)
					ram_size <= dl.data[3:0];
			end

			// Region is only applied between downloads
			if (!cart_dl)
				pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];

			if (cart_dl && !old_dl)
				bk_enable <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_enable <= |ram_mask;
		end
	end

	assign info = '{
		rom_type:  rom_type,
		rom_mask:  rom_mask,
		ram_mask:  ram_mask,
		pal:       pal,
		bk_enable: bk_enable
	};

endmodule

// ==== source/cart_regs.sv ====
// AXI4-Lite configuration and status registers
// CTRL options, CMD load/save pulses, STATUS and mask readback

`include "cart_consts.svh"

module cart_regs (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic [`AXI_ADDR_W-1:0]       s_axi_awaddr,
	input  logic                         s_axi_awvalid,
	output logic                         s_axi_awready,
	input  logic [31:0]                  s_axi_wdata,
	input  logic                         s_axi_wvalid,
	output logic                         s_axi_wready,
	output logic [1:0]                   s_axi_bresp,
	output logic                         s_axi_bvalid,
	input  logic                         s_axi_bready,
	input  logic [`AXI_ADDR_W-1:0]       s_axi_araddr,
	input  logic                         s_axi_arvalid,
	output logic                         s_axi_arready,
	output logic [31:0]                  s_axi_rdata,
	output logic [1:0]                   s_axi_rresp,
	output logic                         s_axi_rvalid,
	input  logic                         s_axi_rready,
	input  cart_pkg::cart_info_t         info,
	input  logic                         bk_busy,
	output cart_pkg::hdr_mode_e          hdr_mode,
	output logic [1:0]                   region_sel,
	output cart_pkg::fill_pat_e          fill_pat,
	output logic                         load_req,
	output logic                         save_req
);
	logic        wr_busy;
	logic        rd_busy;
	logic        wr_start;
	logic        rd_start;
	logic [31:0] rd_mux;

	// One transaction at a time, writes first
	assign wr_busy  = s_axi_awready | s_axi_bvalid;
	assign rd_busy  = s_axi_arready | s_axi_rvalid;
	assign wr_start = s_axi_awvalid & s_axi_wvalid & ~wr_busy & ~rd_busy;
	assign rd_start = s_axi_arvalid & ~wr_busy & ~rd_busy & ~wr_start;

	assign s_axi_wready = s_axi_awready;
	assign s_axi_bresp  = 2'b00;
	assign s_axi_rresp  = 2'b00;

	// ====================
	// Write channel
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			s_axi_awready <= 1'b0;
			s_axi_bvalid  <= 1'b0;
			s_axi_arready <= 1'b0;
			s_axi_rvalid  <= 1'b0;
			hdr_mode      <= cart_pkg::AUTO;
			region_sel    <= 2'd0;
			fill_pat      <= cart_pkg::PAT_9966;
			load_req      <= 1'b0;
			save_req      <= 1'b0;
		end else begin
			load_req      <= 1'b0;
			save_req      <= 1'b0;
			s_axi_awready <= wr_start;
			s_axi_arready <= rd_start;

			if (s_axi_awready) begin
				s_axi_bvalid <= 1'b1;
				case (s_axi_awaddr)
					`REG_CTRL: begin
						hdr_mode   <= cart_pkg::hdr_mode_e'(s_axi_wdata[2:0]);
						region_sel <= s_axi_wdata[5:4];
						fill_pat   <= cart_pkg::fill_pat_e'(s_axi_wdata[9:8]);
					end
					`REG_CMD: begin
						load_req <= s_axi_wdata[0];
						save_req <= s_axi_wdata[1];
					end
					default: ;
				endcase
			end else if (s_axi_bvalid && s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end

			if (s_axi_arready)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rvalid && s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	// ====================
	// Read channel
	// ====================
	always_comb begin
		case (s_axi_araddr)
			`REG_CTRL:     rd_mux = {22'd0, fill_pat, 2'd0, region_sel, 1'b0, hdr_mode};
			`REG_STATUS:   rd_mux = {21'd0, bk_busy, info.bk_enable, info.pal, info.rom_type};
			`REG_ROM_MASK: rd_mux = {8'd0, info.rom_mask};
			`REG_RAM_MASK: rd_mux = {8'd0, info.ram_mask};
			default:       rd_mux = 32'd0;
		endcase
	end

	// Data captured as the address is accepted
	always_ff @(posedge clk_sys) begin
		if (s_axi_arready)
			s_axi_rdata <= rd_mux;
	end

endmodule

// ==== source/dl_if.sv ====
// Download bus interface
// Host side drives, sinks only observe

`include "cart_consts.svh"

interface dl_if;
	logic                   download;
	logic [`DL_INDEX_W-1:0] index;
	logic [`DL_ADDR_W-1:0]  addr;
	logic [`DL_DATA_W-1:0]  data;
	logic                   wr;

	modport host (
		output download, index, addr, data, wr
	);

	// No back-pressure, every wr during download is a word
	modport sink (
		input download, index, addr, data, wr
	);
endinterface

// ==== source/cart_pkg.sv ====
// Shared types for the cartridge loader
// Header mode, fill pattern, cartridge info and cheat record

package cart_pkg;

	// Matches the header option order of the menu
	typedef enum logic [2:0] {
		AUTO      = 3'd0,
		NO_HEADER = 3'd1,
		LOROM     = 3'd2,
		HIROM     = 3'd3,
		EXHIROM   = 3'd4
	} hdr_mode_e;

	// Power-on work RAM contents
	typedef enum logic [1:0] {
		PAT_9966 = 2'd0,
		PAT_00FF = 2'd1,
		PAT_55   = 2'd2,
		PAT_FF   = 2'd3
	} fill_pat_e;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
		logic        bk_enable;
	} cart_info_t;

	// Values are big endian as sent by the host
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

// ==== source/cart_consts.svh ====
// Constants for the cartridge loader
// Bus widths, download indexes, header offsets and register map

`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// Download bus
`define DL_ADDR_W 25
`define DL_DATA_W 16
`define DL_INDEX_W 8
`define IDX_CART 8'h00
`define IDX_CHEAT 8'hFF

// Copier header and ROM header size/RAM bytes per mapping
`define HDR_SKIP 25'd512
`define HDR_LO_SIZE (25'h007FD6 + `HDR_SKIP)
`define HDR_LO_RAM (25'h007FD8 + `HDR_SKIP)
`define HDR_HI_SIZE (25'h00FFD6 + `HDR_SKIP)
`define HDR_HI_RAM (25'h00FFD8 + `HDR_SKIP)
`define HDR_EX_SIZE (25'h40FFD6 + `HDR_SKIP)
`define HDR_EX_RAM (25'h40FFD8 + `HDR_SKIP)

// Work RAM and backup storage
`define CLEAR_ADDR_W 17
`define SECTOR_SHIFT 9

// AXI4-Lite register map
`define AXI_ADDR_W 8
`define REG_CTRL 8'h00
`define REG_CMD 8'h04
`define REG_STATUS 8'h08
`define REG_ROM_MASK 8'h0C
`define REG_RAM_MASK 8'h10

`endif
